// File: fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// the SDRAM window that goes through the instruction cache.
`define FETCH_CACHED_BASE 32'ha000_0000
`define FETCH_CACHED_LIMIT 32'ha200_0000

// line size in words, which is also the burst length.
`define FETCH_LINE_WORDS 4

`define FETCH_SETS 16

// width of the hit and miss counters.
`define FETCH_COUNT_BITS 16

`endif

// File: fetch_pkg.sv
`include "fetch_settings.svh"

package fetch_pkg;

	localparam int WORD_SEL_BITS = $clog2(`FETCH_LINE_WORDS);
	localparam int INDEX_BITS = $clog2(`FETCH_SETS);
	localparam int OFFSET_BITS = WORD_SEL_BITS + 2;
	localparam int TAG_BITS = 32 - INDEX_BITS - OFFSET_BITS;

	typedef logic [31:0] word_t;

	// word 0 sits at the lowest address of the line.
	typedef word_t [`FETCH_LINE_WORDS-1:0] line_t;

	typedef logic [INDEX_BITS-1:0] index_t;
	typedef logic [TAG_BITS-1:0] tag_t;

	function automatic index_t addr_index(input word_t addr);
		return addr[OFFSET_BITS +: INDEX_BITS];
	endfunction

	function automatic tag_t addr_tag(input word_t addr);
		return addr[31 -: TAG_BITS];
	endfunction

	function automatic logic [WORD_SEL_BITS-1:0] addr_word(input word_t addr);
		return addr[2 +: WORD_SEL_BITS];
	endfunction

endpackage

// File: line_store.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module line_store (
	input logic clock,
	input logic reset,

	input logic lookup,
	input fetch_pkg::word_t lookup_addr,
	output logic lookup_done,
	output logic lookup_hit,
	output fetch_pkg::line_t lookup_line,

	input logic fill,
	input fetch_pkg::word_t fill_addr,
	input fetch_pkg::line_t fill_line
);

	logic [`FETCH_SETS-1:0] valid_bits;
	fetch_pkg::tag_t tags [`FETCH_SETS];
	fetch_pkg::line_t lines [`FETCH_SETS];

	fetch_pkg::index_t lookup_index;
	fetch_pkg::tag_t lookup_tag;
	fetch_pkg::index_t fill_index;
	fetch_pkg::tag_t fill_tag;
	logic tag_match;

	assign lookup_index = fetch_pkg::addr_index(lookup_addr);
	assign lookup_tag = fetch_pkg::addr_tag(lookup_addr);
	assign fill_index = fetch_pkg::addr_index(fill_addr);
	assign fill_tag = fetch_pkg::addr_tag(fill_addr);

	assign tag_match = valid_bits[lookup_index] && (tags[lookup_index] == lookup_tag);

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_bits <= '0;
		end else if (fill) begin
			valid_bits[fill_index] <= 1'b1;
		end
	end

	// a fill always brings the whole line, so tag and data are written together.
	always_ff @(posedge clock) begin
		if (fill) begin
			tags[fill_index] <= fill_tag;
			lines[fill_index] <= fill_line;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			lookup_done <= 1'b0;
		end else begin
			lookup_done <= lookup;
		end
	end

	// hit and line only mean something while lookup_done is high.
	always_ff @(posedge clock) begin
		if (lookup) begin
			lookup_hit <= tag_match;
			lookup_line <= lines[lookup_index];
		end
	end

	// the controller fills only at the end of a miss, never while it looks up.
	assert property (@(posedge clock) disable iff (reset) !(fill && lookup))
		else $error("line_store: fill and lookup in the same cycle");

endmodule

// File: burst_reader.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module burst_reader (
	input logic clock,
	input logic reset,

	input logic read_start,
	input logic read_burst,
	input fetch_pkg::word_t read_addr,
	output logic read_done,
	output logic read_error,
	output fetch_pkg::line_t read_line,

	output fetch_pkg::word_t mem_araddr,
	output logic mem_arvalid,
	input logic mem_arready,
	output logic [3:0] mem_arlen,
	output logic [1:0] mem_arburst,
	input fetch_pkg::word_t mem_rdata,
	input logic [1:0] mem_rresp,
	input logic mem_rvalid,
	output logic mem_rready
);

	localparam logic [3:0] BURST_LEN = 4'(`FETCH_LINE_WORDS - 1);
	localparam fetch_pkg::word_t LINE_MASK = ~fetch_pkg::word_t'(`FETCH_LINE_WORDS * 4 - 1);

	typedef enum logic [1:0] {
		IDLE,
		ADDR,
		DATA
	} state_t;

	state_t state;
	logic [fetch_pkg::WORD_SEL_BITS-1:0] beat;
	logic last_beat;
	logic beat_taken;

	assign mem_arvalid = (state == ADDR);
	assign mem_rready = (state == DATA);

	assign beat_taken = mem_rvalid && mem_rready;

	// arlen is 0 or the line length minus one, so its low bits name the last slot.
	assign last_beat = (beat == mem_arlen[fetch_pkg::WORD_SEL_BITS-1:0]);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
			beat <= '0;
			read_done <= 1'b0;
			read_error <= 1'b0;
		end else begin
			read_done <= 1'b0;
			case (state)
				IDLE: begin
					if (read_start) begin
						state <= ADDR;
						beat <= '0;
						read_error <= 1'b0;
					end
				end
				ADDR: begin
					if (mem_arready) begin
						state <= DATA;
					end
				end
				DATA: begin
					if (beat_taken) begin
						beat <= beat + 1'b1;
						read_error <= read_error | mem_rresp[1];
						if (last_beat) begin
							state <= IDLE;
							read_done <= 1'b1;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// a burst starts at the line boundary; a single read uses the exact address.
	always_ff @(posedge clock) begin
		if (state == IDLE && read_start) begin
			if (read_burst) begin
				mem_araddr <= read_addr & LINE_MASK;
				mem_arlen <= BURST_LEN;
				mem_arburst <= 2'b01;
			end else begin
				mem_araddr <= read_addr;
				mem_arlen <= 4'd0;
				mem_arburst <= 2'b00;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (beat_taken) begin
			read_line[beat] <= mem_rdata;
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddr))
		else $error("burst_reader: read address changed before it was accepted");

endmodule

// File: fetch_control.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_control (
	input logic clock,
	input logic reset,
	input logic start,
	input fetch_pkg::word_t pc,
	output fetch_pkg::word_t inst,
	output logic inst_valid,
	output logic fetch_error,
	output logic [`FETCH_COUNT_BITS-1:0] hit_count,
	output logic [`FETCH_COUNT_BITS-1:0] miss_count,

	output logic lookup,
	output fetch_pkg::word_t lookup_addr,
	input logic lookup_done,
	input logic lookup_hit,
	input fetch_pkg::line_t lookup_line,
	output logic fill,
	output fetch_pkg::word_t fill_addr,
	output fetch_pkg::line_t fill_line,

	output logic read_start,
	output logic read_burst,
	output fetch_pkg::word_t read_addr,
	input logic read_done,
	input logic read_error,
	input fetch_pkg::line_t read_line
);

	typedef enum logic [1:0] {
		IDLE,
		LOOKUP,
		READ
	} state_t;

	state_t state;
	fetch_pkg::word_t pc_q;
	logic cached_q;
	logic pc_cached;
	logic [fetch_pkg::WORD_SEL_BITS-1:0] word_sel;

	assign pc_cached = (pc >= `FETCH_CACHED_BASE) && (pc < `FETCH_CACHED_LIMIT);
	assign word_sel = fetch_pkg::addr_word(pc_q);

	// the lookup goes out in the start cycle so a hit returns two cycles later.
	assign lookup = start && pc_cached;
	assign lookup_addr = pc;

	// the reader holds its line until the next read, which cannot start before the fill.
	assign fill_addr = pc_q;
	assign fill_line = read_line;
	assign read_addr = pc_q;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
			inst_valid <= 1'b0;
			fetch_error <= 1'b0;
			fill <= 1'b0;
			read_start <= 1'b0;
			read_burst <= 1'b0;
			hit_count <= '0;
			miss_count <= '0;
		end else begin
			inst_valid <= 1'b0;
			fetch_error <= 1'b0;
			fill <= 1'b0;
			read_start <= 1'b0;
			case (state)
				IDLE: begin
					if (start && pc_cached) begin
						state <= LOOKUP;
					end else if (start) begin
						state <= READ;
						read_start <= 1'b1;
						read_burst <= 1'b0;
					end
				end
				LOOKUP: begin
					if (lookup_done && lookup_hit) begin
						state <= IDLE;
						inst_valid <= 1'b1;
						if (hit_count != '1) begin
							hit_count <= hit_count + 1'b1;
						end
					end else if (lookup_done) begin
						state <= READ;
						read_start <= 1'b1;
						read_burst <= 1'b1;
						if (miss_count != '1) begin
							miss_count <= miss_count + 1'b1;
						end
					end
				end
				READ: begin
					if (read_done) begin
						state <= IDLE;
						inst_valid <= 1'b1;
						fetch_error <= read_error;
						// a faulty line must not be cached.
						fill <= cached_q && !read_error;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == IDLE && start) begin
			pc_q <= pc;
			cached_q <= pc_cached;
		end
	end

	// an uncached read lands its single beat in slot 0.
	always_ff @(posedge clock) begin
		if (state == LOOKUP && lookup_done && lookup_hit) begin
			inst <= lookup_line[word_sel];
		end else if (state == READ && read_done) begin
			inst <= cached_q ? read_line[word_sel] : read_line[0];
		end
	end

	assert property (@(posedge clock) disable iff (reset) start |-> state == IDLE)
		else $error("fetch_control: start while a fetch is in progress");

endmodule

// File: fetch_top.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_top (
	input logic clock,
	input logic reset,
	input logic start,
	input fetch_pkg::word_t pc,
	output fetch_pkg::word_t inst,
	output logic inst_valid,
	output logic fetch_error,
	output logic [`FETCH_COUNT_BITS-1:0] hit_count,
	output logic [`FETCH_COUNT_BITS-1:0] miss_count,

	output fetch_pkg::word_t mem_araddr,
	output logic mem_arvalid,
	input logic mem_arready,
	output logic [3:0] mem_arlen,
	output logic [1:0] mem_arburst,
	input fetch_pkg::word_t mem_rdata,
	input logic [1:0] mem_rresp,
	input logic mem_rvalid,
	output logic mem_rready
);

	logic lookup;
	fetch_pkg::word_t lookup_addr;
	logic lookup_done;
	logic lookup_hit;
	fetch_pkg::line_t lookup_line;
	logic fill;
	fetch_pkg::word_t fill_addr;
	fetch_pkg::line_t fill_line;
	logic read_start;
	logic read_burst;
	fetch_pkg::word_t read_addr;
	logic read_done;
	logic read_error;
	fetch_pkg::line_t read_line;

	line_store store_i (
		.clock(clock),
		.reset(reset),
		.lookup(lookup),
		.lookup_addr(lookup_addr),
		.lookup_done(lookup_done),
		.lookup_hit(lookup_hit),
		.lookup_line(lookup_line),
		.fill(fill),
		.fill_addr(fill_addr),
		.fill_line(fill_line)
	);

	burst_reader reader_i (
		.clock(clock),
		.reset(reset),
		.read_start(read_start),
		.read_burst(read_burst),
		.read_addr(read_addr),
		.read_done(read_done),
		.read_error(read_error),
		.read_line(read_line),
		.mem_araddr(mem_araddr),
		.mem_arvalid(mem_arvalid),
		.mem_arready(mem_arready),
		.mem_arlen(mem_arlen),
		.mem_arburst(mem_arburst),
		.mem_rdata(mem_rdata),
		.mem_rresp(mem_rresp),
		.mem_rvalid(mem_rvalid),
		.mem_rready(mem_rready)
	);

	fetch_control control_i (
		.clock(clock),
		.reset(reset),
		.start(start),
		.pc(pc),
		.inst(inst),
		.inst_valid(inst_valid),
		.fetch_error(fetch_error),
		.hit_count(hit_count),
		.miss_count(miss_count),
		.lookup(lookup),
		.lookup_addr(lookup_addr),
		.lookup_done(lookup_done),
		.lookup_hit(lookup_hit),
		.lookup_line(lookup_line),
		.fill(fill),
		.fill_addr(fill_addr),
		.fill_line(fill_line),
		.read_start(read_start),
		.read_burst(read_burst),
		.read_addr(read_addr),
		.read_done(read_done),
		.read_error(read_error),
		.read_line(read_line)
	);

endmodule

// File: fetch_checker.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_checker (
	input logic clock,
	input logic reset,
	input logic start,
	input fetch_pkg::word_t pc,
	input logic expect_hit,
	input logic inject_error,
	input logic end_of_test,
	input fetch_pkg::word_t inst,
	input logic inst_valid,
	input logic fetch_error,
	input logic [`FETCH_COUNT_BITS-1:0] hit_count,
	input logic [`FETCH_COUNT_BITS-1:0] miss_count,
	input fetch_pkg::word_t mem_araddr,
	input logic mem_arvalid,
	input logic mem_arready,
	input logic [3:0] mem_arlen,
	input logic [1:0] mem_arburst,
	input logic mem_rvalid,
	input logic mem_rready,
	output int value_errors,
	output int other_errors
);

	localparam logic [31:0] LINE_MASK = ~32'(`FETCH_LINE_WORDS * 4 - 1);

	logic model_valid [`FETCH_SETS];
	logic [23:0] model_tag [`FETCH_SETS];
	int hits;
	int misses;
	int cycle;
	int start_cycle;
	int requests;
	int beats_left;
	logic started;
	logic busy;
	logic data_phase;
	fetch_pkg::word_t cur_pc;
	logic cur_cached;
	logic cur_hit;
	logic cur_error;

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			$display("[FAIL] %s: got %h, expected %h", name, got, want);
			value_errors++;
		end
	endtask

	task automatic report_problem(input string what);
		$display("problem at %0t: %s", $time, what);
		other_errors++;
	endtask

	always @(posedge clock) begin
		if (reset) begin
			for (int s = 0; s < `FETCH_SETS; s++) begin
				model_valid[s] = 1'b0;
			end
			started = 1'b0;
			busy = 1'b0;
			data_phase = 1'b0;
			hits = 0;
			misses = 0;
			cycle = 0;
			value_errors = 0;
			other_errors = 0;
		end else begin
			cycle++;
			if (!started && (inst_valid || mem_arvalid)) begin
				report_problem("inst_valid or mem_arvalid went high before the first start");
			end
			// rready is high from address acceptance until the last beat is taken.
			compare_value("mem_rready", 32'(mem_rready), 32'(data_phase));
			if (fetch_error && !inst_valid) begin
				report_problem("fetch_error pulsed without inst_valid");
			end
			if (start) begin
				started = 1'b1;
				busy = 1'b1;
				cur_pc = pc;
				cur_cached = (pc >= `FETCH_CACHED_BASE) && (pc < `FETCH_CACHED_LIMIT);
				cur_hit = cur_cached && model_valid[pc[7:4]] && (model_tag[pc[7:4]] == pc[31:8]);
				cur_error = inject_error;
				if (cur_hit != expect_hit) begin
					report_problem("the stimulus table and the cache model disagree about a hit");
				end
				if (cur_hit) begin
					hits++;
				end else if (cur_cached) begin
					misses++;
				end
				start_cycle = cycle;
				requests = 0;
			end
			if (mem_arvalid && mem_arready) begin
				requests++;
				if (!busy || cur_hit) begin
					report_problem("a memory request was made without a miss or an uncached fetch");
				end
				compare_value("mem_araddr", mem_araddr, cur_cached ? (cur_pc & LINE_MASK) : cur_pc);
				compare_value("mem_arlen", 32'(mem_arlen), cur_cached ? 32'd3 : 32'd0);
				compare_value("mem_arburst", 32'(mem_arburst), cur_cached ? 32'd1 : 32'd0);
				data_phase = 1'b1;
				beats_left = cur_cached ? `FETCH_LINE_WORDS : 1;
			end
			if (mem_rvalid && mem_rready && data_phase) begin
				beats_left--;
				if (beats_left == 0) begin
					data_phase = 1'b0;
				end
			end
			if (inst_valid) begin
				if (!busy) begin
					report_problem("inst_valid pulsed with no fetch in progress");
				end
				compare_value("inst", inst, cur_pc ^ 32'h5a5a_5a5a);
				compare_value("fetch_error", 32'(fetch_error), 32'(cur_error));
				compare_value("hit_count", 32'(hit_count), hits);
				compare_value("miss_count", 32'(miss_count), misses);
				// a hit's inst_valid is sampled two edges after the edge that samples start.
				if (cur_hit && (cycle - start_cycle != 2)) begin
					report_problem("a cache hit did not return two cycles after start");
				end
				if (!cur_hit && requests != 1) begin
					report_problem("a miss or uncached fetch did not make exactly one memory request");
				end
				if (cur_cached && !cur_hit && !cur_error) begin
					model_valid[cur_pc[7:4]] = 1'b1;
					model_tag[cur_pc[7:4]] = cur_pc[31:8];
				end
				busy = 1'b0;
			end
			if (end_of_test) begin
				compare_value("hit_count", 32'(hit_count), hits);
				compare_value("miss_count", 32'(miss_count), misses);
			end
		end
	end

endmodule

// File: fetch_tb.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module fetch_tb;

	localparam int ROWS = 16;
	localparam int RESET_CYCLES = 16;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + ROWS * 200;

	logic clock = 1'b0;
	logic reset;
	logic start;
	fetch_pkg::word_t pc;
	fetch_pkg::word_t inst;
	logic inst_valid;
	logic fetch_error;
	logic [`FETCH_COUNT_BITS-1:0] hit_count;
	logic [`FETCH_COUNT_BITS-1:0] miss_count;
	fetch_pkg::word_t mem_araddr;
	logic mem_arvalid;
	logic mem_arready;
	logic [3:0] mem_arlen;
	logic [1:0] mem_arburst;
	fetch_pkg::word_t mem_rdata;
	logic [1:0] mem_rresp;
	logic mem_rvalid;
	logic mem_rready;

	logic inject_error;
	logic expect_hit;
	logic end_of_test;
	int value_errors;
	int other_errors;
	logic [31:0] lfsr_state = 32'd68575;

	// each row is a pc, an error inject flag and whether the fetch should hit.
	fetch_pkg::word_t row_pc [ROWS] = '{
		32'ha000_0010, 32'ha000_0014, 32'ha000_001c, 32'h0000_1000,
		32'ha000_0110, 32'ha000_0018, 32'ha000_0118, 32'ha000_0114,
		32'ha100_0040, 32'ha100_0044, 32'ha100_0048, 32'ha200_0000,
		32'ha1ff_fff0, 32'ha1ff_fffc, 32'h0000_0ffc, 32'ha000_0010
	};
	logic row_error [ROWS] = '{0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 1, 0};
	logic row_hit [ROWS] = '{0, 1, 1, 0, 0, 0, 0, 1, 0, 0, 1, 0, 0, 1, 0, 0};

	fetch_top dut_i (.*);

	fetch_checker checker_i (.*);

	always #20 clock = ~clock;

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
	endfunction

	// two LFSR bits give a gap of 0 to 3 cycles.
	task automatic draw_gap(output int gap);
		gap = 0;
		repeat (2) begin
			gap = (gap << 1) | int'(lfsr_state[0]);
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	initial begin : responder
		fetch_pkg::word_t base;
		logic [3:0] last;
		logic [1:0] burst;
		int gap;
		forever begin
			@(negedge clock);
			if (!reset && mem_arvalid) begin
				draw_gap(gap);
				repeat (gap) @(negedge clock);
				base = mem_araddr;
				last = mem_arlen;
				burst = mem_arburst;
				mem_arready = 1'b1;
				@(negedge clock);
				mem_arready = 1'b0;
				for (int beat = 0; beat <= int'(last); beat++) begin
					draw_gap(gap);
					repeat (gap) @(negedge clock);
					mem_rvalid = 1'b1;
					mem_rdata = (burst == 2'b01 ? base + 32'(beat * 4) : base) ^ 32'h5a5a_5a5a;
					mem_rresp = inject_error ? 2'b10 : 2'b00;
					@(negedge clock);
					mem_rvalid = 1'b0;
				end
			end
		end
	end

	initial begin
		reset = 1'b1;
		start = 1'b0;
		pc = '0;
		mem_arready = 1'b0;
		mem_rdata = '0;
		mem_rresp = 2'b00;
		mem_rvalid = 1'b0;
		inject_error = 1'b0;
		expect_hit = 1'b0;
		end_of_test = 1'b0;
		repeat (RESET_CYCLES) @(negedge clock);
		reset = 1'b0;
		// a few idle cycles, so an early inst_valid or arvalid would show.
		repeat (4) @(negedge clock);
		for (int row = 0; row < ROWS; row++) begin
			pc = row_pc[row];
			inject_error = row_error[row];
			expect_hit = row_hit[row];
			start = 1'b1;
			@(negedge clock);
			start = 1'b0;
			do begin
				@(negedge clock);
			end while (!inst_valid);
			// the next start waits one cycle because a miss fills the line while inst_valid is high.
			@(negedge clock);
		end
		repeat (4) @(negedge clock);
		end_of_test = 1'b1;
		@(negedge clock);
		end_of_test = 1'b0;
		@(negedge clock);
		$display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("watchdog: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+.
fetch_pkg.sv
line_store.sv
burst_reader.sv
fetch_control.sv
fetch_top.sv
fetch_checker.sv
fetch_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module fetch_tb -o fetch_sim || exit 1
out=$(./obj_dir/fetch_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TEST RESULT: PASS" && exit 0 || exit 1
